/* hw/isa_pkg.sv */
// Instruction-set package: address widths, ALU flags and branch condition codes
package isa_pkg;

    // Program address space
    localparam int addr_width = 16;   // Full PC width
    localparam int page_width = 12;   // Call target inside a 4K page

    typedef logic [addr_width-1:0] addr_t;

    // Branch condition field of the instruction word
    typedef enum logic [2:0] {
        cond_eq     = 3'b000,   // Z
        cond_lt     = 3'b001,   // N and not V
        cond_gt     = 3'b010,   // Not N, not V, not Z
        cond_ov     = 3'b011,   // V
        cond_ne     = 3'b100,   // Not Z
        cond_ge     = 3'b101,   // V or not N
        cond_le     = 3'b110,   // Z or (N and not V)
        cond_always = 3'b111    // Unconditional
    } cond_t;

    // ALU status flags, packed high to low as Z, V, N
    typedef struct packed {
        logic z;   // Result zero
        logic v;   // Signed overflow
        logic n;   // Result negative
    } flags_t;

endpackage

/* hw/flow_pkg.sv */
// Program-flow package: decoded flow requests, PC redirects and return stack sizing
package flow_pkg;

    import isa_pkg::*;

    // Return-address stack geometry
    localparam int stack_depth = 8;
    localparam int sp_width    = 3;   // Index bits, pointer carries one more

    // Kind of control transfer asked for by the decoder
    typedef enum logic [1:0] {
        flow_none   = 2'b00,
        flow_branch = 2'b01,
        flow_call   = 2'b10,
        flow_ret    = 2'b11
    } flow_kind_t;

    // Decoded request, one per instruction
    typedef struct packed {
        flow_kind_t              kind;
        cond_t                   cond;          // Only meaningful for branches
        logic signed [15:0]      offset;        // PC relative branch distance
        logic [page_width-1:0]   call_target;   // Low bits of call destination
    } flow_req_t;

    // New PC and whether to take it
    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

endpackage

/* hw/branch_resolve.sv */
// Branch resolver: turns a flow request, ALU flags and stack top into a PC redirect
module branch_resolve
    import isa_pkg::*, flow_pkg::*;
(
    input  flow_req_t req,
    input  flags_t    flags,
    input  addr_t     pc,
    input  addr_t     stack_top,
    output redirect_t redirect,
    output logic      update_done
);

    logic  cond_true;     // Condition code holds for current flags
    addr_t branch_addr;
    addr_t call_addr;

    // Condition code evaluation against Z, V, N
    function automatic logic cond_met(input cond_t cond, input flags_t f);
        logic met;
        case (cond)
            cond_eq: begin
                met = f.z;
            end
            cond_lt: begin
                met = f.n & ~f.v;
            end
            cond_gt: begin
                met = ~f.n & ~f.v & ~f.z;
            end
            cond_ov: begin
                met = f.v;
            end
            cond_ne: begin
                met = ~f.z;
            end
            cond_ge: begin
                met = f.v | ~f.n;
            end
            cond_le: begin
                met = f.z | (~f.v & f.n);
            end
            default: begin
                met = 1'b1;   // cond_always
            end
        endcase
        return met;
    endfunction

    assign cond_true = cond_met(req.cond, flags);

    // Branch target is formed whether or not the branch is taken
    assign branch_addr = pc + req.offset;

    // Calls stay inside the current 4K page
    assign call_addr = {pc[addr_width-1:page_width], req.call_target};

    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = '0;
        update_done     = 1'b0;
        case (req.kind)
            flow_branch: begin
                redirect.taken  = cond_true;
                redirect.target = branch_addr;
                update_done     = 1'b1;
            end
            flow_call: begin
                redirect.taken  = 1'b1;
                redirect.target = call_addr;
                update_done     = 1'b1;
            end
            flow_ret: begin
                redirect.taken  = 1'b1;
                redirect.target = stack_top;   // Zero when the stack is empty
                update_done     = 1'b1;
            end
            default: begin
                // flow_none leaves the defaults in place
                redirect.taken  = 1'b0;
                redirect.target = '0;
                update_done     = 1'b0;
            end
        endcase
    end

endmodule

/* hw/return_stack.sv */
// Return-address stack: pushes the return PC on call, pops on return, flags over/underflow
module return_stack
    import isa_pkg::*, flow_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  flow_kind_t kind,
    input  addr_t      pc,
    output addr_t      stack_top,
    output logic       stack_error
);

    localparam logic [sp_width:0] full_count = (sp_width + 1)'(stack_depth);

    addr_t             mem [stack_depth];
    logic [sp_width:0] sp;         // Number of valid entries
    logic [sp_width:0] sp_dec;
    logic              empty;
    logic              full;
    logic              do_push;
    logic              do_pop;
    logic              overflow;
    logic              underflow;

    assign empty  = (sp == '0);
    assign full   = (sp == full_count);
    assign sp_dec = sp - 1'b1;

    // Top entry, forced to zero when nothing is stored
    assign stack_top = empty ? '0 : mem[sp_dec[sp_width-1:0]];

    assign overflow  = (kind == flow_call) && full;
    assign underflow = (kind == flow_ret) && empty;

    assign do_push = !stall && (kind == flow_call) && !full;
    assign do_pop  = !stall && (kind == flow_ret) && !empty;

    // Held at zero while the pipe is frozen
    assign stack_error = !stall && (overflow || underflow);

    // Pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            sp <= '0;
        end else if (do_push) begin
            sp <= sp + 1'b1;
        end else if (do_pop) begin
            sp <= sp_dec;
        end
    end

    // Entry storage, return lands after the call instruction
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[sp[sp_width-1:0]] <= pc + 16'd1;
        end
    end

endmodule

/* hw/pc_sequencer.sv */
// PC sequencer: program counter that steps by one, follows a taken redirect or holds
module pc_sequencer
    import isa_pkg::*, flow_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  redirect_t redirect,
    output addr_t     pc
);

    addr_t pc_inc;    // Sequential successor
    addr_t pc_next;

    assign pc_inc = pc + 16'd1;

    // Redirect wins over fall-through, stall wins over both
    always_comb begin
        if (stall) begin
            pc_next = pc;
        end else if (redirect.taken) begin
            pc_next = redirect.target;
        end else begin
            pc_next = pc_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;   // Boot vector
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* hw/program_flow.sv */
// Program-flow unit top: PC sequencer, branch resolver and return-address stack
module program_flow
    import isa_pkg::*, flow_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  flow_req_t req,
    input  flags_t    flags,
    output addr_t     pc,
    output redirect_t redirect,
    output logic      update_done,
    output logic      stack_error
);

    addr_t stack_top;   // Return address for the current request

    pc_sequencer u_pc_sequencer (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .redirect (redirect),
        .pc       (pc)
    );

    // Same-cycle resolution from decoded request
    branch_resolve u_branch_resolve (
        .req         (req),
        .flags       (flags),
        .pc          (pc),
        .stack_top   (stack_top),
        .redirect    (redirect),
        .update_done (update_done)
    );

    return_stack u_return_stack (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .kind        (req.kind),
        .pc          (pc),
        .stack_top   (stack_top),
        .stack_error (stack_error)
    );

endmodule

/* test/program_flow_checker.sv */
// Program-flow checker: concurrent assertions on redirect, stall and return stack errors
module program_flow_checker
    import isa_pkg::*, flow_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      stall,
    input addr_t     pc,
    input redirect_t redirect,
    input logic      update_done,
    input logic      stack_error
);

    timeunit 1ns;
    timeprecision 1ps;

    // A taken redirect only comes from a real request
    property taken_needs_done;
        @(posedge clk) disable iff (reset) redirect.taken |-> update_done;
    endproperty

    property stall_holds_pc;
        @(posedge clk) disable iff (reset) stall |=> $stable(pc);
    endproperty

    property no_error_in_stall;
        @(posedge clk) disable iff (reset) stall |-> !stack_error;
    endproperty

    taken_done_a: assert property (taken_needs_done)
        else $error("redirect taken while update_done is low");
    stall_pc_a: assert property (stall_holds_pc)
        else $error("pc moved across a stalled cycle");
    stall_err_a: assert property (no_error_in_stall)
        else $error("stack_error raised during stall");

endmodule

bind program_flow program_flow_checker chk0 (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .pc          (pc),
    .redirect    (redirect),
    .update_done (update_done),
    .stack_error (stack_error)
);

/* test/program_flow_tb.sv */
// Program-flow testbench: directed and random requests checked against a reference model
module program_flow_tb
    import isa_pkg::*, flow_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int idle_cycles  = 12;
    localparam int cond_cycles  = 64;                  // Eight codes times eight flag sets
    localparam int nest_cycles  = 4 * stack_depth + 3;
    localparam int stall_cycles = 120;
    localparam int mixed_cycles = 400;
    localparam int total_cycles = reset_cycles + idle_cycles + cond_cycles + nest_cycles
                                + stall_cycles + mixed_cycles + 4;

    logic      clk;
    logic      reset;
    logic      stall;
    flow_req_t req;
    flags_t    flags;
    addr_t     pc;
    redirect_t redirect;
    logic      update_done;
    logic      stack_error;

    logic [31:0] rng_state    = 32'hb6fe671c;
    addr_t       model_pc     = '0;
    addr_t       model_stack[$];                       // Return addresses, top at the back
    int          error_pulses = 0;

    program_flow dut0 (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .req         (req),
        .flags       (flags),
        .pc          (pc),
        .redirect    (redirect),
        .update_done (update_done),
        .stack_error (stack_error)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic flags_t rand_flags();
        logic [31:0] bits;
        bits = next_rand();
        return flags_t'(bits[2:0]);
    endfunction

    // Request with random offset and call target
    function automatic flow_req_t make_req(input flow_kind_t k, input cond_t c);
        flow_req_t   r;
        logic [31:0] bits;
        bits          = next_rand();
        r.kind        = k;
        r.cond        = c;
        r.offset      = bits[15:0];
        r.call_target = bits[27:16];
        return r;
    endfunction

    // Expected redirect from the condition table and the target rules
    function automatic redirect_t resolve_ref(input flow_req_t r, input flags_t f,
                                              input addr_t cur_pc, input addr_t top);
        redirect_t res;
        logic      hit;
        case (r.cond)
            cond_eq: hit = f.z;
            cond_lt: hit = f.n && !f.v;
            cond_gt: hit = !f.n && !f.v && !f.z;
            cond_ov: hit = f.v;
            cond_ne: hit = !f.z;
            cond_ge: hit = f.v || !f.n;
            cond_le: hit = f.z || (!f.v && f.n);
            default: hit = 1'b1;
        endcase
        res.taken  = 1'b0;
        res.target = '0;
        if (r.kind == flow_branch) begin
            res.taken  = hit;
            res.target = cur_pc + addr_t'(r.offset);   // Target formed even if not taken
        end else if (r.kind == flow_call) begin
            res.taken  = 1'b1;
            res.target = {cur_pc[addr_width-1:page_width], r.call_target};
        end else if (r.kind == flow_ret) begin
            res.taken  = 1'b1;
            res.target = top;
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail at time %0d ns: %s got %0h expected %0h", $time, name, got, want);
        $display("tests failed");
        $fatal(1, "mismatch against reference model");
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    // One request per cycle, applied on the rising edge
    task automatic drive(input flow_req_t r, input flags_t f, input logic s);
        @(posedge clk);
        req   <= r;
        flags <= f;
        stall <= s;
    endtask

    // Mid-cycle compare, then advance the model to the next edge
    always @(negedge clk) begin
        redirect_t exp_redir;
        logic      exp_done;
        logic      exp_err;
        addr_t     exp_top;
        if (reset) begin
            model_pc = '0;
            model_stack.delete();
        end else begin
            exp_top   = (model_stack.size() == 0) ? '0 : model_stack[$];
            exp_redir = resolve_ref(req, flags, model_pc, exp_top);
            exp_done  = (req.kind != flow_none);
            exp_err   = 1'b0;
            if (!stall && req.kind == flow_call && model_stack.size() >= stack_depth) begin
                exp_err = 1'b1;   // Push dropped
            end
            if (!stall && req.kind == flow_ret && model_stack.size() == 0) begin
                exp_err = 1'b1;
            end

            assert (pc === model_pc)
                else report_mismatch("pc", 32'(pc), 32'(model_pc));
            assert (redirect.taken === exp_redir.taken)
                else report_mismatch("redirect.taken", 32'(redirect.taken), 32'(exp_redir.taken));
            assert (redirect.target === exp_redir.target)
                else report_mismatch("redirect.target", 32'(redirect.target),
                                     32'(exp_redir.target));
            assert (update_done === exp_done)
                else report_mismatch("update_done", 32'(update_done), 32'(exp_done));
            assert (stack_error === exp_err)
                else report_mismatch("stack_error", 32'(stack_error), 32'(exp_err));

            if (stack_error === 1'b1) begin
                error_pulses++;
            end

            if (!stall) begin
                if (req.kind == flow_call && model_stack.size() < stack_depth) begin
                    model_stack.push_back(model_pc + 16'd1);
                end else if (req.kind == flow_ret && model_stack.size() > 0) begin
                    void'(model_stack.pop_back());
                end
                model_pc = exp_redir.taken ? exp_redir.target : model_pc + 16'd1;
            end
        end
    end

    initial begin
        flow_req_t   idle_req;
        logic [31:0] bits;
        idle_req = '0;
        reset    = 1'b1;
        stall    = 1'b0;
        req      = '0;
        flags    = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        // Sequential fetch only
        repeat (idle_cycles) drive(idle_req, rand_flags(), 1'b0);

        for (int c = 0; c < 8; c++) begin
            for (int fl = 0; fl < 8; fl++) begin
                drive(make_req(flow_branch, cond_t'(c[2:0])), flags_t'(fl[2:0]), 1'b0);
            end
        end

        // Nest to full depth and unwind
        for (int i = 0; i < stack_depth; i++) begin
            drive(make_req(flow_call, cond_always), rand_flags(), 1'b0);
        end
        for (int i = 0; i < stack_depth; i++) begin
            drive(make_req(flow_ret, cond_always), rand_flags(), 1'b0);
        end

        // One past full, then one past empty
        for (int i = 0; i <= stack_depth; i++) begin
            drive(make_req(flow_call, cond_always), rand_flags(), 1'b0);
        end
        for (int i = 0; i <= stack_depth; i++) begin
            drive(make_req(flow_ret, cond_always), rand_flags(), 1'b0);
        end
        drive(idle_req, rand_flags(), 1'b0);
        assert (error_pulses == 2)
            else report_mismatch("stack_error pulse count", 32'(error_pulses), 32'd2);

        for (int i = 0; i < stall_cycles; i++) begin
            bits = next_rand();
            drive(make_req(flow_kind_t'(bits[1:0]), cond_t'(bits[4:2])), rand_flags(), bits[5]);
        end

        for (int i = 0; i < mixed_cycles; i++) begin
            bits = next_rand();
            drive(make_req(flow_kind_t'(bits[1:0]), cond_t'(bits[4:2])), rand_flags(),
                  bits[7:5] == 3'b000);
        end

        drive(idle_req, rand_flags(), 1'b0);
        @(posedge clk);
        $display("all tests passed");
        $finish;
    end

    // Run length plus some slack
    initial begin
        #((total_cycles + 100) * clk_period);
        fail_run("watchdog timeout, stimulus did not complete");
    end

endmodule

/* all.f */
hw/isa_pkg.sv
hw/flow_pkg.sv
hw/branch_resolve.sv
hw/return_stack.sv
hw/pc_sequencer.sv
hw/program_flow.sv
test/program_flow_checker.sv
test/program_flow_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the program-flow testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module program_flow_tb \
    -f all.f \
    -o program_flow_sim

./obj_dir/program_flow_sim
